// ==== verilog.f ====
source/panelPkg.sv
source/panelConfig.sv
source/frameBuffer.sv
source/scanDriver.sv
source/ledPanel.sv
tb/panelChecker.sv
tb/ledPanelTb.sv

// ==== Makefile ====
SIM := obj_dir/ledPanelSim
SOURCES := $(wildcard source/*.sv tb/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f verilog.f --top-module ledPanelTb --Mdir obj_dir -o ledPanelSim

# fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qxF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== tb/ledPanelTb.sv ====
`default_nettype none

module ledPanelTb
    import panelPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ClockPeriod = 4;
    localparam int ByteCount = 1 << ByteAddrBits;
    // one frame is every row and plane, plus two latches to see the wrap
    localparam int FrameSteps = HalfHeight * PlaneCount;
    localparam int BrightnessRounds = 5;
    localparam int StepsPerRound = 24;
    localparam int RewriteCount = 300;
    // longest row and plane step at full brightness
    localparam int MaxStepCycles = ShiftCount + 1 + (1 << OnTimeBits);
    localparam int TotalSteps = 2 * (FrameSteps + 2) + BrightnessRounds * StepsPerRound;
    localparam int WriteCycles = ByteCount + 2 * RewriteCount;
    localparam int TimeLimit = (TotalSteps * MaxStepCycles + WriteCycles + 1000) * ClockPeriod;

    localparam logic [2:0] TestReset = 3'd0;
    localparam logic [2:0] TestFrame = 3'd1;
    localparam logic [2:0] TestBright = 3'd2;
    localparam logic [2:0] TestRestart = 3'd3;
    localparam logic [2:0] TestDone = 3'd4;

    logic ClockA;
    logic rstN;
    HostWrite hostWrite;
    ConfigWrite cfgWrite;
    wire PanelDrive drive;
    logic [2:0] testId;
    int errorTotal;
    int seed;

    ledPanel ledPanel_i (
        .ClockA    (ClockA),
        .rstN      (rstN),
        .hostWrite (hostWrite),
        .cfgWrite  (cfgWrite),
        .drive     (drive)
    );

    panelChecker panelChecker_i (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .hostWrite  (hostWrite),
        .cfgWrite   (cfgWrite),
        .drive      (drive),
        .testId     (testId),
        .errorTotal (errorTotal)
    );

    initial begin
        ClockA = 1'b0;
        forever #(ClockPeriod / 2) ClockA = ~ClockA;
    end

    // one byte per cycle, back to back when called in a loop
    task automatic writeByte(input logic [ByteAddrBits-1:0] addr, input logic [ByteBits-1:0] data);
        @(posedge ClockA);
        hostWrite.valid <= 1'b1;
        hostWrite.addr.flat <= addr;
        hostWrite.data <= data;
    endtask

    task automatic endWrites();
        @(posedge ClockA);
        hostWrite.valid <= 1'b0;
    endtask

    task automatic writeConfig(input logic which, input logic [ByteBits-1:0] data);
        @(posedge ClockA);
        cfgWrite <= '{valid: 1'b1, select: which, data: data};
        @(posedge ClockA);
        cfgWrite.valid <= 1'b0;
    endtask

    // each latch closes one row and plane step
    task automatic waitLatches(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(negedge ClockA);
            if (drive.latch) begin
                seen++;
            end
        end
    endtask

    initial begin
        logic [31:0] rnd;
        seed = 32'hdfea;
        hostWrite = '0;
        cfgWrite = '0;
        testId = TestReset;
        rstN = 1'b0;
        repeat (3) begin
            @(posedge ClockA);
        end
        rstN <= 1'b1;

        // fill every byte while the driver sits idle
        for (int a = 0; a < ByteCount; a++) begin
            rnd = $random(seed);
            writeByte(a[ByteAddrBits-1:0], rnd[ByteBits-1:0]);
        end
        endWrites();

        // full frame at one random brightness
        @(posedge ClockA);
        testId <= TestFrame;
        rnd = $random(seed);
        writeConfig(SelectBrightness, {4'b0, rnd[3:0]});
        writeConfig(SelectEnable, 8'h01);
        waitLatches(FrameSteps + 2);

        // brightness moves while scanning
        @(posedge ClockA);
        testId <= TestBright;
        repeat (BrightnessRounds) begin
            rnd = $random(seed);
            writeConfig(SelectBrightness, {4'b0, rnd[3:0]});
            waitLatches(StepsPerRound);
        end

        // stop, patch random bytes, scan again from the top
        @(posedge ClockA);
        testId <= TestRestart;
        writeConfig(SelectEnable, 8'h00);
        repeat (RewriteCount) begin
            rnd = $random(seed);
            writeByte(rnd[ByteAddrBits-1:0], rnd[23:16]);
        end
        endWrites();
        writeConfig(SelectEnable, 8'h01);
        waitLatches(FrameSteps + 2);

        @(posedge ClockA);
        testId <= TestDone;
        // checker prints its summary first
        repeat (2) begin
            @(posedge ClockA);
        end
        if (errorTotal == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog sized from writes plus worst case scan steps
    initial begin
        #(TimeLimit);
        $display("timeout: the scan did not reach the expected latches within %0d ns", TimeLimit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/panelChecker.sv ====
`default_nettype none

module panelChecker
    import panelPkg::*;
(
    input  wire logic       ClockA,
    input  wire logic       rstN,
    input  wire HostWrite   hostWrite,
    input  wire ConfigWrite cfgWrite,
    input  wire PanelDrive  drive,
    input  wire logic [2:0] testId,
    output int              errorTotal
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TestCount = 4;

    // mirror of frame memory and config registers, built from host strobes
    logic [ByteBits-1:0] mem [1 << ByteAddrBits];
    logic modelEnable = 1'b0;
    logic [BrightnessBits-1:0] modelBright = '0;
    // driver was reset or disabled at the last edge
    logic driverReset = 1'b0;

    // where the scan should be
    logic [RowBits-1:0] expRow = '0;
    logic [PlaneBits-1:0] expPlane = '0;
    int strobeCount = 0;
    // display stretch after a latch
    logic measuring = 1'b0;
    int lowCount = 0;
    int expOnTime = 0;

    // last entry collects checks after the final test
    string testNames [TestCount + 1] = '{"reset state", "frame scan", "brightness",
                                         "restart", "wind down"};
    int checks [TestCount + 1] = '{default: 0};
    int errors [TestCount + 1] = '{default: 0};
    int current = 0;
    int totalChecks = 0;
    int errorCount = 0;

    assign errorTotal = errorCount;

    // plane bits of one pixel, red and blue from bit p+1, green from bit p+2
    function automatic logic [2:0] expectedBits(
        input logic                  half,
        input logic [RowBits-1:0]    row,
        input logic [ColumnBits-1:0] column,
        input logic [PlaneBits-1:0]  plane
    );
        logic [15:0] pixel;
        logic [15:0] shifted;
        // byte select 1 holds the high byte
        pixel = {mem[{half, row, column, 1'b1}], mem[{half, row, column, 1'b0}]};
        shifted = pixel >> plane;
        // RGB565 is red 15:11, green 10:5, blue 4:0
        return {shifted[12], shifted[7], shifted[1]};
    endfunction

    task automatic checkValue(input string what, input int expected, input int actual);
        checks[current]++;
        totalChecks++;
        if (expected != actual) begin
            errors[current]++;
            errorCount++;
            $display("FAILED %s, %s: expected %0d actual %0d",
                     testNames[current], what, expected, actual);
        end
    endtask

    // sampled mid-cycle, inputs and outputs both settled
    always @(negedge ClockA) begin
        logic [ColumnBits-1:0] column;
        // a new test id closes the running test
        if (int'(testId) != current) begin
            $display("test %s: %0d checks, %0d errors",
                     testNames[current], checks[current], errors[current]);
            current = int'(testId);
            if (current == TestCount) begin
                $display("summary: %0d tests, %0d checks, %0d errors",
                         TestCount, totalChecks, errorCount);
            end
        end
        if (driverReset) begin
            // idle panel, scan restarts from row 0 plane 0
            checkValue("blank while idle", 1, int'(drive.blank));
            checkValue("strobe while idle", 0, int'(drive.shiftStrobe));
            checkValue("latch while idle", 0, int'(drive.latch));
            checkValue("row while idle", 0, int'(drive.rowAddr));
            expRow = '0;
            expPlane = '0;
            strobeCount = 0;
            measuring = 1'b0;
        end else begin
            if (drive.shiftStrobe) begin
                column = strobeCount[ColumnBits-1:0];
                checkValue($sformatf("top bits row %0d column %0d plane %0d",
                                     expRow, column, expPlane),
                           int'(expectedBits(1'b0, expRow, column, expPlane)),
                           int'(drive.rgbTop));
                checkValue($sformatf("bottom bits row %0d column %0d plane %0d",
                                     expRow, column, expPlane),
                           int'(expectedBits(1'b1, expRow, column, expPlane)),
                           int'(drive.rgbBottom));
                strobeCount++;
            end
            if (drive.latch) begin
                checkValue("strobes before latch", PanelWidth, strobeCount);
                checkValue("row after latch", int'(expRow), int'(drive.rowAddr));
                checkValue("blank during latch", 1, int'(drive.blank));
                // brightness taken in the latch cycle
                expOnTime = (int'(modelBright) + 1) << expPlane;
                measuring = 1'b1;
                lowCount = 0;
                strobeCount = 0;
                // planes inner, rows outer, both wrap
                if (expPlane == PlaneBits'(PlaneCount - 1)) begin
                    expRow = expRow + 1'b1;
                end
                expPlane = expPlane + 1'b1;
            end else if (measuring) begin
                if (!drive.blank) begin
                    lowCount++;
                end else begin
                    checkValue($sformatf("display cycles plane %0d", expPlane - 1'b1),
                               expOnTime, lowCount);
                    measuring = 1'b0;
                end
            end
        end
        // disabled now means reset at the coming edge
        driverReset = !rstN || !modelEnable;
        // strobes seen now land at the coming edge
        if (!rstN) begin
            modelEnable = 1'b0;
            modelBright = '0;
        end else if (cfgWrite.valid) begin
            if (cfgWrite.select == SelectBrightness) begin
                modelBright = cfgWrite.data[BrightnessBits-1:0];
            end else begin
                modelEnable = cfgWrite.data[0];
            end
        end
        if (hostWrite.valid) begin
            mem[hostWrite.addr.flat] = hostWrite.data;
        end
    end

endmodule

`default_nettype wire

// ==== source/ledPanel.sv ====
`default_nettype none

module ledPanel
    import panelPkg::*;
(
    input  wire logic       ClockA,
    input  wire logic       rstN,
    input  wire HostWrite   hostWrite,
    input  wire ConfigWrite cfgWrite,
    output wire PanelDrive  drive
);

    // config registers to the scan driver
    wire ScanSettings settings;

    // scan driver read port into the frame buffer
    wire logic readEnable;
    wire logic [IndexBits-1:0] readIndex;
    wire ColumnPair columnData;

    // enable and brightness
    panelConfig panelConfig_i (
        .ClockA   (ClockA),
        .rstN     (rstN),
        .cfgWrite (cfgWrite),
        .settings (settings)
    );

    // host writes bytes, scan driver reads column pairs
    frameBuffer frameBuffer_i (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .hostWrite  (hostWrite),
        .readEnable (readEnable),
        .readIndex  (readIndex),
        .columnData (columnData)
    );

    // row, plane and column sequencing onto the panel lines
    scanDriver scanDriver_i (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .settings   (settings),
        .readEnable (readEnable),
        .readIndex  (readIndex),
        .columnData (columnData),
        .drive      (drive)
    );

endmodule

`default_nettype wire

// ==== source/scanDriver.sv ====
`default_nettype none

module scanDriver
    import panelPkg::*;
(
    input  wire logic                 ClockA,
    input  wire logic                 rstN,
    input  wire ScanSettings          settings,
    output logic                      readEnable,
    output logic [IndexBits-1:0]      readIndex,
    input  wire ColumnPair            columnData,
    output PanelDrive                 drive
);

    ScanState state;

    // position in the frame
    logic [RowBits-1:0] row;
    logic [PlaneBits-1:0] plane;
    // counts reads, then the drain cycles of the read pipeline
    logic [ShiftCountBits-1:0] column;

    // row currently shown on the panel
    logic [RowBits-1:0] shownRow;

    // display countdown and its load value
    logic [OnTimeBits-1:0] onCount;
    logic [OnTimeBits:0] onTime;

    // one bit per read in flight, aligned with columnData at the top
    logic [ReadLatency-1:0] validPipe;
    logic strobe;

    // pick this plane's bits from one pixel
    // red and blue use bits 1..4, green uses bits 2..5
    function automatic logic [2:0] planeBits(
        input Rgb565                pixel,
        input logic [PlaneBits-1:0] p
    );
        return {pixel.red[p + 1], pixel.green[p + 2], pixel.blue[p + 1]};
    endfunction

    // on-time is (brightness + 1) << plane
    assign onTime = ((OnTimeBits + 1)'(settings.brightness) + 1'b1) << plane;

    // reads only in the first 64 cycles of shift
    assign readEnable = (state == ScanShift) && (column < ShiftCountBits'(PanelWidth));
    assign readIndex = {row, column[ColumnBits-1:0]};

    assign strobe = validPipe[ReadLatency-1];

    always_ff @(posedge ClockA) begin
        if (!rstN || !settings.enable) begin
            // clearing enable aborts the scan in the next cycle
            state <= ScanIdle;
            row <= '0;
            plane <= '0;
            column <= '0;
            shownRow <= '0;
            onCount <= '0;
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[ReadLatency-2:0], readEnable};
            case (state)
                ScanIdle: begin
                    state <= ScanShift;
                end
                ScanShift: begin
                    if (column == ShiftCountBits'(ShiftCount - 1)) begin
                        // last strobe is out, latch the row just shifted
                        column <= '0;
                        shownRow <= row;
                        state <= ScanLatch;
                    end else begin
                        column <= column + 1'b1;
                    end
                end
                ScanLatch: begin
                    // brightness is sampled here for the whole display stretch
                    onCount <= OnTimeBits'(onTime - 1'b1);
                    state <= ScanDisplay;
                end
                ScanDisplay: begin
                    if (onCount == '0) begin
                        // planes inner, rows outer, both wrap
                        plane <= plane + 1'b1;
                        if (plane == PlaneBits'(PlaneCount - 1)) begin
                            row <= row + 1'b1;
                        end
                        state <= ScanShift;
                    end else begin
                        onCount <= onCount - 1'b1;
                    end
                end
                default: begin
                    state <= ScanIdle;
                end
            endcase
        end
    end

    // panel lines
    always_comb begin
        drive.shiftStrobe = strobe;
        // colour lines stay low between strobes
        drive.rgbTop = strobe ? planeBits(columnData.top, plane) : 3'b000;
        drive.rgbBottom = strobe ? planeBits(columnData.bottom, plane) : 3'b000;
        drive.latch = (state == ScanLatch);
        drive.blank = (state != ScanDisplay);
        drive.rowAddr = shownRow;
    end

    // the read pipeline is empty by the time latch fires
    latchAfterShift: assert property (
        @(posedge ClockA) disable iff (!rstN)
        !(drive.latch && drive.shiftStrobe)
    ) else $error("latch overlaps a shift strobe");

    // never latch onto a lit row
    latchWhileBlank: assert property (
        @(posedge ClockA) disable iff (!rstN)
        drive.latch |-> drive.blank
    ) else $error("latch while panel unblanked");

    // frame buffer is only read while shifting
    readOnlyInShift: assert property (
        @(posedge ClockA) disable iff (!rstN)
        readEnable |-> (state == ScanShift)
    ) else $error("frame buffer read outside shift");

endmodule

`default_nettype wire

// ==== source/frameBuffer.sv ====
`default_nettype none

module frameBuffer
    import panelPkg::*;
(
    input  wire logic                 ClockA,
    input  wire logic                 rstN,
    input  wire HostWrite             hostWrite,
    input  wire logic                 readEnable,
    input  wire logic [IndexBits-1:0] readIndex,
    output ColumnPair                 columnData
);

    // four banks, one per half and byte select
    // bank number is {half, byteSel}
    //   bank 0  top half, low byte
    //   bank 1  top half, high byte
    //   bank 2  bottom half, low byte
    //   bank 3  bottom half, high byte
    logic [ByteBits-1:0] bankMem [BankCount][BankDepth];

    // write side decode through the field view of the union
    PixelAddrFields wrFields;
    logic [BankBits-1:0] wrBank;
    logic [IndexBits-1:0] wrIndex;

    // read side stage one, the raw bytes of all four banks
    logic [BankCount-1:0][ByteBits-1:0] bankBytes;
    logic stageOneValid;

    assign wrFields = hostWrite.addr.fields;
    assign wrBank = {wrFields.half, wrFields.byteSel};
    // row and column together index a bank
    assign wrIndex = {wrFields.row, wrFields.column};

    // single byte writes, one per strobe
    always_ff @(posedge ClockA) begin
        if (hostWrite.valid) begin
            bankMem[wrBank][wrIndex] <= hostWrite.data;
        end
    end

    // stage one gathers the same index from every bank
    // a write to the same location in this cycle is not seen yet
    always_ff @(posedge ClockA) begin
        if (readEnable) begin
            for (int b = 0; b < BankCount; b++) begin
                bankBytes[b] <= bankMem[b][readIndex];
            end
        end
    end

    // track which stage one contents came from a real read
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            stageOneValid <= 1'b0;
        end else begin
            stageOneValid <= readEnable;
        end
    end

    // stage two pairs the bytes into the two RGB565 pixels
    // high byte comes from the byteSel 1 bank of each half
    always_ff @(posedge ClockA) begin
        if (stageOneValid) begin
            columnData.top <= {bankBytes[1], bankBytes[0]};
            columnData.bottom <= {bankBytes[3], bankBytes[2]};
        end
    end

endmodule

`default_nettype wire

// ==== source/panelConfig.sv ====
`default_nettype none

module panelConfig
    import panelPkg::*;
(
    input  wire logic       ClockA,
    input  wire logic       rstN,
    input  wire ConfigWrite cfgWrite,
    output ScanSettings     settings
);

    // register file of two entries
    // enable lives in bit 0 of its write data
    // brightness lives in the low nibble
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            settings.enable <= 1'b0;
            settings.brightness <= '0;
        end else if (cfgWrite.valid) begin
            // select picks the register, the other one holds
            if (cfgWrite.select == SelectBrightness) begin
                settings.brightness <= cfgWrite.data[BrightnessBits-1:0];
            end else begin
                settings.enable <= cfgWrite.data[0];
            end
        end
    end

    // a write strobe is the only way the scan settings move
    settingsNeedStrobe: assert property (
        @(posedge ClockA) disable iff (!rstN)
        (settings != $past(settings)) |-> $past(cfgWrite.valid)
    ) else $error("scan settings changed without a config strobe");

endmodule

`default_nettype wire

// ==== source/panelPkg.sv ====
`default_nettype none

package panelPkg;

    // panel geometry, two halves of 16 rows by 64 columns
    localparam int PanelWidth = 64;
    localparam int HalfHeight = 16;
    localparam int RowBits = 4;
    localparam int ColumnBits = 6;

    // binary-coded modulation over the top four bits of each channel
    localparam int PlaneCount = 4;
    localparam int PlaneBits = 2;
    localparam int BrightnessBits = 4;

    // memory organization
    localparam int ByteBits = 8;
    localparam int BankBits = 2;
    localparam int BankCount = 1 << BankBits;
    localparam int IndexBits = RowBits + ColumnBits;
    localparam int BankDepth = HalfHeight * PanelWidth;
    localparam int ByteAddrBits = 12;
    localparam int ReadLatency = 2;

    // scan timing
    // shift state covers 64 reads plus the read pipeline drain
    localparam int ShiftCount = PanelWidth + ReadLatency;
    localparam int ShiftCountBits = 7;
    // longest on-time is 16 << 3 = 128 cycles, counted down from 127
    localparam int OnTimeBits = BrightnessBits + PlaneCount - 1;

    // config register select
    localparam logic SelectEnable = 1'b0;
    localparam logic SelectBrightness = 1'b1;

    // memory view of a host byte address
    // byteSel 1 is the high byte of the RGB565 pixel
    typedef struct packed {
        logic                  half;
        logic [RowBits-1:0]    row;
        logic [ColumnBits-1:0] column;
        logic                  byteSel;
    } PixelAddrFields;

    // host sees a flat byte address, frame buffer splits it into bank and index
    typedef union packed {
        logic [ByteAddrBits-1:0] flat;
        PixelAddrFields          fields;
    } PixelAddr;

    typedef struct packed {
        logic                valid;
        PixelAddr            addr;
        logic [ByteBits-1:0] data;
    } HostWrite;

    typedef struct packed {
        logic                valid;
        logic                select;
        logic [ByteBits-1:0] data;
    } ConfigWrite;

    typedef struct packed {
        logic                      enable;
        logic [BrightnessBits-1:0] brightness;
    } ScanSettings;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } Rgb565;

    typedef struct packed {
        Rgb565 top;
        Rgb565 bottom;
    } ColumnPair;

    typedef struct packed {
        logic               shiftStrobe;
        logic [2:0]         rgbTop;
        logic [2:0]         rgbBottom;
        logic               latch;
        logic               blank;
        logic [RowBits-1:0] rowAddr;
    } PanelDrive;

    typedef enum logic [1:0] {
        ScanIdle,
        ScanShift,
        ScanLatch,
        ScanDisplay
    } ScanState;

endpackage

`default_nettype wire
